//--- hdl/mips_mem_pkg.sv
package mips_mem_pkg;

    typedef logic [31:0] word_t;      // Data or address word
    typedef logic [15:0] half_t;      // Immediate field
    typedef logic [5:0]  opcode_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  byte_en_t;   // Bit 3 is the most significant byte internally

    localparam opcode_t OPC_LB  = 6'h20;
    localparam opcode_t OPC_LH  = 6'h21;
    localparam opcode_t OPC_LWL = 6'h22;
    localparam opcode_t OPC_LW  = 6'h23;
    localparam opcode_t OPC_LBU = 6'h24;
    localparam opcode_t OPC_LHU = 6'h25;
    localparam opcode_t OPC_LWR = 6'h26;
    localparam opcode_t OPC_SB  = 6'h28;
    localparam opcode_t OPC_SH  = 6'h29;
    localparam opcode_t OPC_SW  = 6'h2B;
    localparam opcode_t OPC_LUI = 6'h0F;

    localparam word_t RESET_PC  = 32'h0000_0000;
    localparam int    REG_COUNT = 32;

    typedef enum logic [3:0] {
        op_none, op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwl, op_lwr,
        op_sb, op_sh, op_sw, op_lui
    } mem_op_e;

    // Phases of one instruction
    typedef enum logic [1:0] {
        st_fetch = 2'b00,
        st_exec1 = 2'b01,
        st_exec2 = 2'b10
    } cycle_state_e;

    typedef struct packed {
        mem_op_e   op;
        reg_addr_t rs;
        reg_addr_t rt;
        half_t     offset;
    } decoded_instr_t;

    typedef struct packed {
        word_t    address;
        byte_en_t byteenable;   // Bit i enables the byte at address + i
        word_t    writedata;
        logic     read;
        logic     write;
    } avalon_req_t;

    typedef struct packed {
        logic      valid;       // One-cycle strobe
        reg_addr_t addr;
        word_t     data;
    } reg_write_t;

endpackage

//--- hdl/instr_sequencer.sv
`timescale 1ns/1ps

module instr_sequencer (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       waitrequest,
    input  logic                       mem_busy,
    output mips_mem_pkg::cycle_state_e state,
    output mips_mem_pkg::word_t        pc,
    output logic                       retire,
    output mips_mem_pkg::word_t        retire_pc
);

    mips_mem_pkg::cycle_state_e next_state;
    logic                       advance;

    // A pending bus access holds everything until waitrequest drops
    assign advance = !mem_busy || !waitrequest;

    always_comb begin
        case (state)
            mips_mem_pkg::st_fetch: next_state = mips_mem_pkg::st_exec1;
            mips_mem_pkg::st_exec1: next_state = mips_mem_pkg::st_exec2;
            default:                next_state = mips_mem_pkg::st_fetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mips_mem_pkg::st_fetch;
            pc    <= mips_mem_pkg::RESET_PC;
        end else if (advance) begin
            state <= next_state;
            if (state == mips_mem_pkg::st_exec2) begin
                pc <= pc + 32'd4;   // Always sequential without branches
            end
        end
    end

    assign retire    = (state == mips_mem_pkg::st_exec2) && advance;
    assign retire_pc = pc;            // PC only moves after retire

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        state inside {mips_mem_pkg::st_fetch, mips_mem_pkg::st_exec1,
                      mips_mem_pkg::st_exec2});

    // PC stays on word boundaries
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00);

endmodule

//--- hdl/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  mips_mem_pkg::word_t          instr,
    output mips_mem_pkg::decoded_instr_t dec
);

    mips_mem_pkg::opcode_t opcode;

    assign opcode = instr[31:26];

    always_comb begin
        // Every supported op uses the I-type fields
        dec.rs     = instr[25:21];
        dec.rt     = instr[20:16];
        dec.offset = instr[15:0];
        case (opcode)
            mips_mem_pkg::OPC_LB: begin
                dec.op = mips_mem_pkg::op_lb;
            end
            mips_mem_pkg::OPC_LBU: begin
                dec.op = mips_mem_pkg::op_lbu;
            end
            mips_mem_pkg::OPC_LH: begin
                dec.op = mips_mem_pkg::op_lh;
            end
            mips_mem_pkg::OPC_LHU: begin
                dec.op = mips_mem_pkg::op_lhu;
            end
            mips_mem_pkg::OPC_LW: begin
                dec.op = mips_mem_pkg::op_lw;
            end
            mips_mem_pkg::OPC_LWL: begin
                dec.op = mips_mem_pkg::op_lwl;    // Merges into upper bytes of rt
            end
            mips_mem_pkg::OPC_LWR: begin
                dec.op = mips_mem_pkg::op_lwr;    // Merges into lower bytes of rt
            end
            mips_mem_pkg::OPC_SB: begin
                dec.op = mips_mem_pkg::op_sb;
            end
            mips_mem_pkg::OPC_SH: begin
                dec.op = mips_mem_pkg::op_sh;
            end
            mips_mem_pkg::OPC_SW: begin
                dec.op = mips_mem_pkg::op_sw;
            end
            mips_mem_pkg::OPC_LUI: begin
                dec.op = mips_mem_pkg::op_lui;
            end
            // Everything else retires as a no-op
            default: begin
                dec.op = mips_mem_pkg::op_none;
            end
        endcase
    end

endmodule

//--- hdl/load_store.sv
`timescale 1ns/1ps

module load_store (
    input  logic                         clk,
    input  logic                         reset,
    input  mips_mem_pkg::cycle_state_e   state,
    input  mips_mem_pkg::word_t          pc,
    input  mips_mem_pkg::decoded_instr_t dec,
    input  mips_mem_pkg::word_t          rs_data,
    input  mips_mem_pkg::word_t          rt_data,
    output mips_mem_pkg::avalon_req_t    bus_req,
    input  mips_mem_pkg::word_t          bus_readdata,
    input  logic                         waitrequest,
    output logic                         mem_busy,
    output mips_mem_pkg::word_t          instr,
    output mips_mem_pkg::reg_write_t     reg_wr
);

    mips_mem_pkg::word_t    offset_ext;
    mips_mem_pkg::word_t    eff_addr;
    logic [1:0]             byte_sel;
    mips_mem_pkg::word_t    rdata;        // Big-endian view of bus_readdata
    mips_mem_pkg::word_t    wdata;        // Big-endian store data
    mips_mem_pkg::byte_en_t be;           // Bit 3 is offset 0 internally
    mips_mem_pkg::word_t    instr_q;
    mips_mem_pkg::word_t    load_q;
    mips_mem_pkg::word_t    load_data;
    logic [7:0]             sel_byte;
    logic [15:0]            sel_half;
    logic                   is_load;
    logic                   is_store;

    // Reverses the four bytes of a word
    function automatic mips_mem_pkg::word_t swap_bytes(input mips_mem_pkg::word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    assign is_load = dec.op inside {mips_mem_pkg::op_lb, mips_mem_pkg::op_lbu,
                                    mips_mem_pkg::op_lh, mips_mem_pkg::op_lhu,
                                    mips_mem_pkg::op_lw, mips_mem_pkg::op_lwl,
                                    mips_mem_pkg::op_lwr};
    assign is_store = dec.op inside {mips_mem_pkg::op_sb, mips_mem_pkg::op_sh,
                                     mips_mem_pkg::op_sw};

    assign offset_ext = {{16{dec.offset[15]}}, dec.offset};
    assign eff_addr   = rs_data + offset_ext;
    assign byte_sel   = eff_addr[1:0];
    assign rdata      = swap_bytes(bus_readdata);

    // Enables and lane placement of the data access
    always_comb begin
        be    = 4'b1111;
        wdata = rt_data;
        case (dec.op)
            mips_mem_pkg::op_lb, mips_mem_pkg::op_lbu: be = 4'b1000 >> byte_sel;
            mips_mem_pkg::op_lh, mips_mem_pkg::op_lhu: be = byte_sel[1] ? 4'b0011 : 4'b1100;
            mips_mem_pkg::op_lwl: be = 4'b1111 >> byte_sel;
            mips_mem_pkg::op_lwr: be = 4'b1111 << (2'd3 - byte_sel);
            mips_mem_pkg::op_sb: begin
                be    = 4'b1000 >> byte_sel;
                wdata = {4{rt_data[7:0]}};     // Enables pick the lane
            end
            mips_mem_pkg::op_sh: begin
                be    = byte_sel[1] ? 4'b0011 : 4'b1100;
                wdata = {2{rt_data[15:0]}};
            end
            default: ;                          // lw, sw and non-memory ops
        endcase
    end

    always_comb begin
        bus_req.read       = 1'b0;
        bus_req.write      = 1'b0;
        bus_req.byteenable = 4'b1111;
        bus_req.writedata  = swap_bytes(wdata);
        bus_req.address    = {eff_addr[31:2], 2'b00};
        case (state)
            mips_mem_pkg::st_fetch: begin
                bus_req.read    = 1'b1;
                bus_req.address = pc;
            end
            mips_mem_pkg::st_exec1: begin
                bus_req.read       = is_load;
                bus_req.write      = is_store;
                bus_req.byteenable = {be[0], be[1], be[2], be[3]};  // Lane 0 is offset 0
            end
            default: ;
        endcase
    end

    assign mem_busy = bus_req.read || bus_req.write;

    // Capture on the completing edge of each access
    always_ff @(posedge clk) begin
        if (state == mips_mem_pkg::st_fetch && !waitrequest) begin
            instr_q <= rdata;
        end
        if (state == mips_mem_pkg::st_exec1 && is_load && !waitrequest) begin
            load_q <= rdata;
        end
    end

    assign instr = instr_q;

    assign sel_byte = load_q[(3 - byte_sel) * 8 +: 8];
    assign sel_half = byte_sel[1] ? load_q[15:0] : load_q[31:16];

    // rs and rt are still unchanged in EXEC2 while the write-back value forms
    always_comb begin
        load_data = load_q;
        case (dec.op)
            mips_mem_pkg::op_lb:  load_data = {{24{sel_byte[7]}}, sel_byte};
            mips_mem_pkg::op_lbu: load_data = {24'h000000, sel_byte};
            mips_mem_pkg::op_lh:  load_data = {{16{sel_half[15]}}, sel_half};
            mips_mem_pkg::op_lhu: load_data = {16'h0000, sel_half};
            mips_mem_pkg::op_lui: load_data = {dec.offset, 16'h0000};
            mips_mem_pkg::op_lwl: begin
                case (byte_sel)
                    2'b00: load_data = load_q;
                    2'b01: load_data = {load_q[23:0], rt_data[7:0]};
                    2'b10: load_data = {load_q[15:0], rt_data[15:0]};
                    2'b11: load_data = {load_q[7:0], rt_data[23:0]};
                endcase
            end
            mips_mem_pkg::op_lwr: begin
                case (byte_sel)
                    2'b00: load_data = {rt_data[31:8], load_q[31:24]};
                    2'b01: load_data = {rt_data[31:16], load_q[31:16]};
                    2'b10: load_data = {rt_data[31:24], load_q[31:8]};
                    2'b11: load_data = load_q;
                endcase
            end
            default: ;                          // lw passes the word through
        endcase
    end

    assign reg_wr.valid = (state == mips_mem_pkg::st_exec2)
                          && (is_load || dec.op == mips_mem_pkg::op_lui);
    assign reg_wr.addr  = dec.rt;
    assign reg_wr.data  = load_data;

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
        !(bus_req.read && bus_req.write));

    a_be_nonzero: assert property (@(posedge clk) disable iff (reset)
        mem_busy |-> bus_req.byteenable != 4'b0000);

    // Held request also means the register file saw no write meanwhile
    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        (mem_busy && waitrequest) |=> $stable(bus_req));

endmodule

//--- hdl/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                     clk,
    input  logic                     reset,
    input  mips_mem_pkg::reg_addr_t  rs_addr,
    input  mips_mem_pkg::reg_addr_t  rt_addr,
    output mips_mem_pkg::word_t      rs_data,
    output mips_mem_pkg::word_t      rt_data,
    input  mips_mem_pkg::reg_write_t wr
);

    mips_mem_pkg::word_t regs [mips_mem_pkg::REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < mips_mem_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid && wr.addr != 5'd0) begin
            regs[wr.addr] <= wr.data;   // Writes to r0 are dropped
        end
    end

    // Asynchronous reads
    // r0 forced to zero on the read side as well
    assign rs_data = (rs_addr == 5'd0) ? 32'h0000_0000 : regs[rs_addr];
    assign rt_data = (rt_addr == 5'd0) ? 32'h0000_0000 : regs[rt_addr];

endmodule

//--- hdl/mips_mem_subsys.sv
`timescale 1ns/1ps

module mips_mem_subsys (
    input  logic                      clk,
    input  logic                      reset,
    output mips_mem_pkg::avalon_req_t bus_req,
    input  mips_mem_pkg::word_t       bus_readdata,
    input  logic                      waitrequest,
    output mips_mem_pkg::reg_write_t  reg_wr,
    output logic                      retire,
    output mips_mem_pkg::word_t       retire_pc
);

    mips_mem_pkg::cycle_state_e   state;
    mips_mem_pkg::word_t          pc;
    mips_mem_pkg::word_t          instr;      // Instruction register contents
    mips_mem_pkg::decoded_instr_t dec;
    mips_mem_pkg::word_t          rs_data;
    mips_mem_pkg::word_t          rt_data;
    logic                         mem_busy;

    instr_sequencer u_instr_sequencer (
        .clk         (clk),
        .reset       (reset),
        .waitrequest (waitrequest),
        .mem_busy    (mem_busy),
        .state       (state),
        .pc          (pc),
        .retire      (retire),
        .retire_pc   (retire_pc)
    );

    instr_decoder u_instr_decoder (
        .instr (instr),
        .dec   (dec)
    );

    // Bus side and write-back
    load_store u_load_store (
        .clk          (clk),
        .reset        (reset),
        .state        (state),
        .pc           (pc),
        .dec          (dec),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .bus_req      (bus_req),
        .bus_readdata (bus_readdata),
        .waitrequest  (waitrequest),
        .mem_busy     (mem_busy),
        .instr        (instr),
        .reg_wr       (reg_wr)
    );

    // Base from rs, merge source and store data from rt
    register_file u_register_file (
        .clk     (clk),
        .reset   (reset),
        .rs_addr (dec.rs),
        .rt_addr (dec.rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr      (reg_wr)
    );

endmodule

//--- sim/avalon_mem_model.sv
`timescale 1ns/1ps

module avalon_mem_model (
    input  logic                      clk,
    input  mips_mem_pkg::avalon_req_t bus_req,
    output mips_mem_pkg::word_t       readdata,
    output logic                      waitrequest
);

    localparam int MEM_BYTES = 65536;   // Decodes the low 16 address bits

    logic [7:0]  mem [MEM_BYTES];
    integer      seed;
    int          wait_left;
    logic        in_access;
    logic [15:0] base;

    initial begin
        seed        = 32'h4dca_8362;
        in_access   = 1'b0;
        wait_left   = 0;
        readdata    = '0;
        waitrequest = 1'b0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem[i] = i[7:0] ^ i[15:8];
        end
    end

    // Outputs change on the falling edge for the DUT to sample on the rising edge
    always @(negedge clk) begin
        if (bus_req.read || bus_req.write) begin
            if (!in_access) begin
                in_access = 1'b1;
                wait_left = $unsigned($random(seed)) % 3;   // 0 to 2 wait states
            end
            if (wait_left > 0) begin
                waitrequest <= 1'b1;
                wait_left = wait_left - 1;
            end else begin
                waitrequest <= 1'b0;   // Completes on the next rising edge
                in_access = 1'b0;
                base      = bus_req.address[15:0];
                readdata <= {mem[base + 3], mem[base + 2], mem[base + 1], mem[base]};
                for (int i = 0; i < 4; i++) begin
                    if (bus_req.write && bus_req.byteenable[i]) begin
                        mem[base + i] = bus_req.writedata[8 * i +: 8];   // Lane i is base + i
                    end
                end
            end
        end else begin
            waitrequest <= 1'b0;
        end
    end

    // The byte at addr is the top byte of the big-endian word
    task automatic load_word(input mips_mem_pkg::word_t addr, input mips_mem_pkg::word_t data);
        for (int i = 0; i < 4; i++) begin
            mem[addr[15:0] + i] = data[31 - 8 * i -: 8];
        end
    endtask

    function automatic logic [7:0] read_byte(input mips_mem_pkg::word_t addr);
        return mem[addr[15:0]];
    endfunction

endmodule

//--- sim/tb_mips_mem_subsys.sv
`timescale 1ns/1ps

module tb_mips_mem_subsys;

    typedef mips_mem_pkg::word_t word_t;

    localparam int MAX_INSTR   = 64;
    localparam int CYCLE_LIMIT = MAX_INSTR * 3 * 3 + 64;   // 3 phases of up to 3 cycles

    logic                      clk;
    logic                      reset;
    mips_mem_pkg::avalon_req_t bus_req;
    word_t                     bus_readdata;
    logic                      waitrequest;
    mips_mem_pkg::reg_write_t  reg_wr;
    logic                      retire;
    word_t                     retire_pc;

    word_t      ref_regs [32];
    logic [7:0] ref_mem [65536];    // Same 16-bit decode as the memory model
    word_t      prog [$];           // Instructions of the running test
    word_t      load_pc = mips_mem_pkg::RESET_PC;
    word_t      exp_pc  = mips_mem_pkg::RESET_PC;
    int         errors  = 0;
    int         passed  = 0;
    int         failed  = 0;
    int         cycles  = 0;
    int         stalls  = 0;

    mips_mem_subsys u_mips_mem_subsys (
        .clk          (clk),
        .reset        (reset),
        .bus_req      (bus_req),
        .bus_readdata (bus_readdata),
        .waitrequest  (waitrequest),
        .reg_wr       (reg_wr),
        .retire       (retire),
        .retire_pc    (retire_pc)
    );

    avalon_mem_model u_mem_model (
        .clk         (clk),
        .bus_req     (bus_req),
        .readdata    (bus_readdata),
        .waitrequest (waitrequest)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (5) @(negedge clk);
        reset = 1'b0;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (waitrequest) begin
            stalls <= stalls + 1;   // Model raises it only for a pending access
        end
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the instruction stream stopped", cycles);
            $display("tests failed");
            $finish;
        end
    end

    function automatic logic [7:0] ref_byte(input word_t addr);
        return ref_mem[addr[15:0]];
    endfunction

    task automatic set_byte(input word_t addr, input logic [7:0] data);
        ref_mem[addr[15:0]] = data;
    endtask

    task automatic put_word(input word_t addr, input word_t data);
        u_mem_model.load_word(addr, data);
        for (int i = 0; i < 4; i++) begin
            set_byte(addr + i, data[31 - 8 * i -: 8]);
        end
    endtask

    task automatic emit(input logic [5:0] opc, input logic [4:0] rs, input logic [4:0] rt,
                        input logic [15:0] imm);
        put_word(load_pc, {opc, rs, rt, imm});
        prog.push_back({opc, rs, rt, imm});
        load_pc = load_pc + 32'd4;
    endtask

    // MIPS-I semantics on the big-endian reference memory
    task automatic ref_exec(input word_t instr, output logic wr_valid, output word_t wr_data);
        logic [4:0]  rt;
        word_t       ea;
        word_t       rtv;
        word_t       res;
        logic [7:0]  b0;
        logic [15:0] h0;
        rt  = instr[20:16];
        ea  = ref_regs[instr[25:21]] + {{16{instr[15]}}, instr[15:0]};
        rtv = ref_regs[rt];
        res = rtv;
        b0  = ref_byte(ea);
        h0  = {ref_byte(ea), ref_byte(ea + 1)};
        wr_valid = 1'b1;
        case (instr[31:26])
            mips_mem_pkg::OPC_LB:  res = {{24{b0[7]}}, b0};
            mips_mem_pkg::OPC_LBU: res = {24'h000000, b0};
            mips_mem_pkg::OPC_LH:  res = {{16{h0[15]}}, h0};
            mips_mem_pkg::OPC_LHU: res = {16'h0000, h0};
            mips_mem_pkg::OPC_LW:  res = {h0, ref_byte(ea + 2), ref_byte(ea + 3)};
            mips_mem_pkg::OPC_LUI: res = {instr[15:0], 16'h0000};
            mips_mem_pkg::OPC_LWL: begin
                // From ea to the end of its word, filling rt from the top byte
                for (int i = 0; i <= 3 - ea[1:0]; i++) begin
                    res[31 - 8 * i -: 8] = ref_byte(ea + i);
                end
            end
            mips_mem_pkg::OPC_LWR: begin
                for (int i = 0; i <= ea[1:0]; i++) begin
                    res[8 * i +: 8] = ref_byte(ea - i);   // Word start up to ea, into the bottom
                end
            end
            mips_mem_pkg::OPC_SB: begin
                wr_valid = 1'b0;
                set_byte(ea, rtv[7:0]);
            end
            mips_mem_pkg::OPC_SH: begin
                wr_valid = 1'b0;
                set_byte(ea, rtv[15:8]);
                set_byte(ea + 1, rtv[7:0]);
            end
            mips_mem_pkg::OPC_SW: begin
                wr_valid = 1'b0;
                for (int i = 0; i < 4; i++) begin
                    set_byte(ea + i, rtv[31 - 8 * i -: 8]);
                end
            end
            default: wr_valid = 1'b0;
        endcase
        if (wr_valid && rt != 5'd0) begin
            ref_regs[rt] = res;
        end
        wr_data = res;
    endtask

    // Follows one retire per instruction and checks its write-back
    task automatic run_program();
        logic  exp_valid;
        word_t exp_data;
        foreach (prog[k]) begin
            ref_exec(prog[k], exp_valid, exp_data);
            do begin
                @(negedge clk);
                assert (retire || !reg_wr.valid) else begin
                    $display("Register write strobe seen without a retire, pc %h", retire_pc);
                    errors++;
                end
            end while (!retire);
            assert (retire_pc == exp_pc) else begin
                $display("ERROR retire_pc expected %h actual %h", exp_pc, retire_pc);
                errors++;
            end
            assert (reg_wr.valid == exp_valid) else begin
                $display("ERROR reg_wr.valid expected %h actual %h", exp_valid, reg_wr.valid);
                errors++;
            end
            assert (!exp_valid || reg_wr.addr == prog[k][20:16]) else begin
                $display("ERROR reg_wr.addr expected %h actual %h", prog[k][20:16], reg_wr.addr);
                errors++;
            end
            assert (!exp_valid || reg_wr.data == exp_data) else begin
                $display("ERROR reg_wr.data expected %h actual %h", exp_data, reg_wr.data);
                errors++;
            end
            exp_pc = exp_pc + 32'd4;
        end
        prog.delete();
    endtask

    task automatic finish_test(input string name);
        if (errors == 0) begin
            $display("PASS %s", name);
            passed++;
        end else begin
            $display("FAIL %s with %0d errors", name, errors);
            failed++;
        end
        errors = 0;
    endtask

    task automatic test_fetch_order();
        emit(6'h00, 5'd0, 5'd0, 16'h0000);   // sll, no-op here
        emit(6'h08, 5'd0, 5'd1, 16'h0005);   // addi
        emit(6'h3F, 5'd2, 5'd3, 16'h1234);
        emit(6'h00, 5'd4, 5'd5, 16'h1820);   // add
        emit(6'h04, 5'd1, 5'd1, 16'hFFFF);   // beq never branches
        run_program();
        finish_test("fetch_order");
    endtask

    task automatic test_lui_lw();
        put_word(32'h0000_0800, 32'hDEAD_BEEF);
        put_word(32'h0000_9000, 32'h1357_9BDF);
        put_word(32'h0000_0A40, 32'h0F1E_2D3C);
        emit(mips_mem_pkg::OPC_LUI, 5'd0, 5'd1, 16'h8765);
        emit(mips_mem_pkg::OPC_LW, 5'd0, 5'd2, 16'h0800);
        emit(mips_mem_pkg::OPC_LUI, 5'd0, 5'd3, 16'h0001);   // Base 0x10000
        emit(mips_mem_pkg::OPC_LW, 5'd3, 5'd4, 16'h9000);    // 0x10000 - 0x7000
        emit(mips_mem_pkg::OPC_LW, 5'd3, 5'd5, 16'h0A40);    // 0x10A40 decodes to 0x0A40
        run_program();
        finish_test("lui_lw");
    endtask

    task automatic test_subword_loads();
        put_word(32'h0000_0900, 32'h807F_FE01);
        for (int k = 0; k < 4; k++) begin
            emit(mips_mem_pkg::OPC_LB, 5'd0, 5'(6 + k), 16'(16'h0900 + k));
            emit(mips_mem_pkg::OPC_LBU, 5'd0, 5'(6 + k), 16'(16'h0900 + k));
        end
        for (int k = 0; k < 2; k++) begin
            emit(mips_mem_pkg::OPC_LH, 5'd0, 5'(6 + k), 16'(16'h0900 + 2 * k));
            emit(mips_mem_pkg::OPC_LHU, 5'd0, 5'(8 + k), 16'(16'h0900 + 2 * k));
        end
        run_program();
        finish_test("subword_loads");
    endtask

    task automatic test_unaligned_merge();
        put_word(32'h0000_0910, 32'hCAFE_BABE);
        put_word(32'h0000_0920, 32'h1122_3344);   // Prior rt value
        for (int k = 0; k < 4; k++) begin
            emit(mips_mem_pkg::OPC_LW, 5'd0, 5'd11, 16'h0920);
            emit(mips_mem_pkg::OPC_LWL, 5'd0, 5'd11, 16'(16'h0910 + k));
        end
        for (int k = 0; k < 4; k++) begin
            emit(mips_mem_pkg::OPC_LW, 5'd0, 5'd12, 16'h0920);
            emit(mips_mem_pkg::OPC_LWR, 5'd0, 5'd12, 16'(16'h0910 + k));
        end
        run_program();
        finish_test("unaligned_merge");
    endtask

    task automatic test_stores();
        put_word(32'h0000_0A00, 32'h0102_0304);
        put_word(32'h0000_0A04, 32'h0506_0708);
        put_word(32'h0000_0A08, 32'h090A_0B0C);
        emit(mips_mem_pkg::OPC_LW, 5'd0, 5'd13, 16'h0920);
        emit(mips_mem_pkg::OPC_SB, 5'd0, 5'd13, 16'h0A01);
        emit(mips_mem_pkg::OPC_LW, 5'd0, 5'd14, 16'h0A00);
        emit(mips_mem_pkg::OPC_SH, 5'd0, 5'd13, 16'h0A06);
        emit(mips_mem_pkg::OPC_LW, 5'd0, 5'd14, 16'h0A04);
        emit(mips_mem_pkg::OPC_SW, 5'd0, 5'd13, 16'h0A08);
        emit(mips_mem_pkg::OPC_LW, 5'd0, 5'd14, 16'h0A08);
        emit(mips_mem_pkg::OPC_SB, 5'd0, 5'd13, 16'h0A03);
        emit(mips_mem_pkg::OPC_SH, 5'd0, 5'd13, 16'h0A00);
        emit(mips_mem_pkg::OPC_LW, 5'd0, 5'd14, 16'h0A00);
        run_program();
        for (int a = 16'h0A00; a < 16'h0A0C; a++) begin
            assert (u_mem_model.read_byte(a) == ref_mem[a]) else begin
                $display("ERROR mem[%h] expected %h actual %h", a[15:0], ref_mem[a],
                         u_mem_model.read_byte(a));
                errors++;
            end
        end
        finish_test("stores");
    endtask

    task automatic test_wait_states();
        int stalls_before;
        stalls_before = stalls;
        put_word(32'h0000_0B00, 32'h2468_ACE0);
        for (int k = 0; k < 4; k++) begin
            emit(mips_mem_pkg::OPC_LW, 5'd0, 5'd15, 16'h0B00);
            emit(mips_mem_pkg::OPC_SW, 5'd0, 5'd15, 16'(16'h0B04 + 4 * k));
            emit(mips_mem_pkg::OPC_LBU, 5'd0, 5'd16, 16'(16'h0B04 + 5 * k));
            emit(6'h00, 5'd0, 5'd0, 16'h0000);
        end
        run_program();
        assert (stalls > stalls_before) else begin
            $display("No wait states were inserted while the test ran");
            errors++;
        end
        finish_test("wait_states");
    endtask

    initial begin
        for (int i = 0; i < 65536; i++) begin
            ref_mem[i] = i[7:0] ^ i[15:8];   // Fill pattern of the memory model
        end
        foreach (ref_regs[r]) begin
            ref_regs[r] = '0;
        end
        @(negedge clk);   // First program lands while reset is still high
        test_fetch_order();
        test_lui_lw();
        test_subword_loads();
        test_unaligned_merge();
        test_stores();
        test_wait_states();
        $display("Summary: passed %0d, failed %0d", passed, failed);
        if (failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- flist.f
hdl/mips_mem_pkg.sv
hdl/instr_sequencer.sv
hdl/instr_decoder.sv
hdl/load_store.sv
hdl/register_file.sv
hdl/mips_mem_subsys.sv
sim/avalon_mem_model.sv
sim/tb_mips_mem_subsys.sv
